//--- dcache_tag_top.f
rtl/dcache_pkg.sv
rtl/dtag_req.sv
rtl/dtag_way.sv
rtl/dtag_resolve.sv
rtl/dcache_tag_top.sv
tb/dcache_tag_chk.sv
tb/tb_dcache_tag.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert \
    --top-module tb_dcache_tag \
    -f dcache_tag_top.f \
    -o sim_dcache_tag
./obj_dir/sim_dcache_tag

//--- tb/tb_dcache_tag.sv
`timescale 1ns/1ps

module tb_dcache_tag;
    import dcache_pkg::*;

    localparam int index_bits  = 3;  // 8 sets, lots of conflicts
    localparam int tag_bits    = def_tag_bits;
    localparam int offset_bits = def_offset_bits;
    localparam int num_sets    = 1 << index_bits;

    typedef logic [index_bits-1:0]  index_t;
    typedef logic [tag_bits-1:0]    tag_t;
    typedef logic [offset_bits-1:0] offset_t;

    typedef struct packed {
        int unsigned due;           // cycle count when outputs show it
        logic        is_lookup;     // else expect complete
        logic        hit;
        way_t        hit_way;
        logic        hit_dirty;
        way_t        victim_way;
        logic        victim_valid;
        tag_t        victim_tag;
        logic        victim_dirty;
    } exp_t;

    logic                                       clk, arst_n;
    logic                                       lookup, fill, mark_dirty, fill_dirty;
    logic [index_bits+tag_bits+offset_bits-1:0] addr;
    way_t                                       fill_way;
    logic                                       resp_valid, hit, hit_dirty, complete;
    logic                                       victim_valid, victim_dirty;
    way_t                                       hit_way, victim_way;
    tag_t                                       victim_tag;

    tag_t        model_tag   [num_sets][num_ways];  // reference tag array
    logic        model_valid [num_sets][num_ways];
    logic        model_dirty [num_sets][num_ways];
    way_t        model_lru   [num_sets];            // names the victim
    exp_t        exp_q [$];                         // outstanding results, oldest first
    tag_t        tag_pool [6];
    logic [31:0] rng_state;
    int unsigned cycle;
    string       test_name;

    dcache_tag_top #(
        .index_bits(index_bits), .tag_bits(tag_bits), .offset_bits(offset_bits)
    ) dut0 (.*);

    always #2 clk = ~clk;  // 4 ns period

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic int unsigned rand_below(input int unsigned n);
        rng_state = xorshift32(rng_state);
        return rng_state % n;
    endfunction

    task automatic stop_run(input string why);
        $display("TEST FAILED");
        $fatal(1, "%s", why);
    endtask

    task automatic report_value(input string field, input logic [31:0] exp_val,
                                input logic [31:0] act_val);
        $display("CHECK FAILED %s: %s expected %0h actual %0h",
                 test_name, field, exp_val, act_val);
        stop_run("DUT output differs from the reference model");
    endtask

    task automatic check_lookup(input logic exp_valid, input logic exp_hit,
                                input way_t exp_way, input logic exp_dirty);
        if (resp_valid !== exp_valid) report_value("resp_valid", 32'(exp_valid), 32'(resp_valid));
        if (exp_valid && hit !== exp_hit) report_value("hit", 32'(exp_hit), 32'(hit));
        if (exp_valid && exp_hit) begin  // way and dirty only mean something on a hit
            if (hit_way !== exp_way) report_value("hit_way", 32'(exp_way), 32'(hit_way));
            if (hit_dirty !== exp_dirty) report_value("hit_dirty", 32'(exp_dirty), 32'(hit_dirty));
        end
    endtask

    task automatic check_victim(input way_t exp_way, input logic exp_valid,
                                input tag_t exp_tag, input logic exp_dirty);
        if (victim_way !== exp_way) report_value("victim_way", 32'(exp_way), 32'(victim_way));
        if (victim_valid !== exp_valid) begin
            report_value("victim_valid", 32'(exp_valid), 32'(victim_valid));
        end
        if (exp_valid) begin  // empty ways hold stale ram contents
            if (victim_tag !== exp_tag) report_value("victim_tag", 32'(exp_tag), 32'(victim_tag));
            if (victim_dirty !== exp_dirty) begin
                report_value("victim_dirty", 32'(exp_dirty), 32'(victim_dirty));
            end
        end
    endtask

    task automatic check_complete(input logic exp_comp);
        if (complete !== exp_comp) report_value("complete", 32'(exp_comp), 32'(complete));
    endtask

    // per-cycle scoreboard, pulses must land exactly on their due cycle
    task automatic check_outputs();
        exp_t e;
        logic want_resp;
        logic want_comp;
        e         = '0;
        want_resp = 1'b0;
        want_comp = 1'b0;
        if (exp_q.size() != 0 && exp_q[0].due == cycle) begin
            e         = exp_q.pop_front();
            want_resp = e.is_lookup;
            want_comp = ~e.is_lookup;
        end
        check_lookup(want_resp, e.hit, e.hit_way, e.hit_dirty);
        if (want_resp) check_victim(e.victim_way, e.victim_valid, e.victim_tag, e.victim_dirty);
        check_complete(want_comp);
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;  // outputs settled, safe to drive
        cycle++;
        check_outputs();
        lookup     = 1'b0;
        fill       = 1'b0;
        mark_dirty = 1'b0;
    endtask

    task automatic send_lookup(input index_t set, input tag_t tag);
        exp_t e;
        logic found;
        e     = '0;
        found = 1'b0;
        next_cycle();
        for (int w = 0; w < num_ways; w++) begin
            if (!found && model_valid[set][w] && model_tag[set][w] == tag) begin
                found     = 1'b1;
                e.hit_way = way_t'(w);  // lowest matching way
            end
        end
        if (found) model_lru[set] = ~e.hit_way;  // lru updated before victim pick
        e.victim_way = model_lru[set];
        for (int w = num_ways - 1; w >= 0; w--) begin
            if (!model_valid[set][w]) e.victim_way = way_t'(w);  // empty way first
        end
        e.due          = cycle + 3;
        e.is_lookup    = 1'b1;
        e.hit          = found;
        e.hit_dirty    = model_dirty[set][e.hit_way];
        e.victim_valid = model_valid[set][e.victim_way];
        e.victim_tag   = model_tag[set][e.victim_way];
        e.victim_dirty = model_dirty[set][e.victim_way];
        exp_q.push_back(e);
        lookup = 1'b1;
        addr   = {tag, set, offset_t'(rand_below(1 << offset_bits))};
    endtask

    task automatic fill_line(input index_t set, input tag_t tag, input way_t way,
                             input logic dirty);
        exp_t e;
        e = '0;
        next_cycle();
        model_tag[set][way]   = tag;
        model_valid[set][way] = 1'b1;
        model_dirty[set][way] = dirty;
        model_lru[set]        = ~way;  // filled way becomes most recent
        e.due                 = cycle + 3;
        exp_q.push_back(e);
        fill       = 1'b1;
        fill_way   = way;
        fill_dirty = dirty;
        addr       = {tag, set, offset_t'(rand_below(1 << offset_bits))};
    endtask

    task automatic mark_line_dirty(input index_t set, input way_t way);
        exp_t e;
        e = '0;
        next_cycle();
        model_dirty[set][way] = 1'b1;  // valid, tag and lru untouched
        e.due                 = cycle + 3;
        exp_q.push_back(e);
        mark_dirty = 1'b1;
        fill_way   = way;
        addr       = {tag_pool[rand_below(6)], set, offset_t'(rand_below(1 << offset_bits))};
    endtask

    initial begin
        int unsigned op;
        int unsigned wait_cycles;
        index_t      set;
        tag_t        tag;
        clk        = 1'b0;
        arst_n     = 1'b0;
        lookup     = 1'b0;
        fill       = 1'b0;
        mark_dirty = 1'b0;
        addr       = '0;
        fill_way   = '0;
        fill_dirty = 1'b0;
        rng_state  = 32'hf712768e;
        cycle      = 0;
        test_name  = "reset_miss";
        tag_pool   = '{21'h0a5a5, 21'h1f00f, 21'h00001, 21'h12345, 21'h1ffff, 21'h0c3c3};
        for (int s = 0; s < num_sets; s++) begin
            model_lru[s] = '0;
            for (int w = 0; w < num_ways; w++) begin
                model_tag[s][w]   = '0;
                model_valid[s][w] = 1'b0;
                model_dirty[s][w] = 1'b0;
            end
        end
        repeat (3) @(posedge clk);
        #1;
        arst_n = 1'b1;

        for (int s = 0; s < num_sets; s++) send_lookup(index_t'(s), tag_pool[s % 6]);

        test_name = "fill_hit";
        fill_line(3'd2, tag_pool[0], way_t'(1), 1'b0);
        send_lookup(3'd2, tag_pool[0]);  // back to back with the fill
        send_lookup(3'd2, tag_pool[1]);  // same set, other tag

        test_name = "mark_dirty";
        mark_line_dirty(3'd2, way_t'(1));
        send_lookup(3'd2, tag_pool[0]);
        fill_line(3'd2, tag_pool[1], way_t'(0), 1'b0);
        send_lookup(3'd2, tag_pool[1]);  // way 0 stays clean
        send_lookup(3'd2, tag_pool[2]);  // victim is the dirty way 1

        test_name = "lru_order";
        send_lookup(3'd2, tag_pool[0]);
        send_lookup(3'd2, tag_pool[3]);  // lru written one cycle earlier
        send_lookup(3'd2, tag_pool[1]);
        send_lookup(3'd2, tag_pool[3]);
        fill_line(3'd2, tag_pool[4], way_t'(1), 1'b1);
        send_lookup(3'd2, tag_pool[5]);
        repeat (4) next_cycle();

        test_name = "random";
        for (int i = 0; i < 400; i++) begin
            op  = rand_below(8);
            set = index_t'(rand_below(num_sets));
            tag = tag_pool[rand_below(6)];
            if (op < 3) send_lookup(set, tag);
            else if (op < 5) fill_line(set, tag, way_t'(rand_below(num_ways)), 1'(rand_below(2)));
            else if (op == 5) mark_line_dirty(set, way_t'(rand_below(num_ways)));
            else next_cycle();  // idle gap
        end

        test_name   = "drain";
        wait_cycles = 0;
        while (exp_q.size() != 0 && wait_cycles < 8) begin
            next_cycle();
            wait_cycles++;
        end
        repeat (3) next_cycle();  // no stray pulses after the last result
        if (exp_q.size() == 0) begin
            $display("TEST OK");
            $finish;
        end else begin
            stop_run("timeout while waiting for outstanding results");
        end
    end

endmodule

//--- tb/dcache_tag_chk.sv
`timescale 1ns/1ps

module dcache_tag_chk (
    input logic                              clk,
    input logic                              arst_n,
    input logic                              lookup,
    input logic                              fill,
    input logic                              mark_dirty,
    input logic                              resp_valid,
    input logic                              complete,
    input logic                              hit,
    input dcache_pkg::way_t                  hit_way,
    input logic [dcache_pkg::num_ways-1:0]   line_valid   // way read outputs before resolve
);
    import dcache_pkg::*;

    logic [num_ways-1:0] valid_seen;  // valid bits as the resolve stage latched them

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_seen <= '0;
        end else begin
            valid_seen <= line_valid;  // lines up with hit
        end
    end

    // controller sends one request per cycle at most
    one_strobe: assert property (@(posedge clk) disable iff (!arst_n)
        $onehot0({lookup, fill, mark_dirty}))
        else $error("more than one request strobe high in one cycle");

    // lookups and writes never finish in the same cycle
    resp_or_complete: assert property (@(posedge clk) disable iff (!arst_n)
        !(resp_valid && complete))
        else $error("resp_valid and complete high together");

    // a hit must come from a valid line
    hit_on_valid: assert property (@(posedge clk) disable iff (!arst_n)
        hit |-> valid_seen[hit_way])
        else $error("hit reported on a way whose valid bit is clear");

endmodule

bind dcache_tag_top dcache_tag_chk u_chk (
    .clk(clk),
    .arst_n(arst_n),
    .lookup(lookup),
    .fill(fill),
    .mark_dirty(mark_dirty),
    .resp_valid(resp_valid),
    .complete(complete),
    .hit(hit),
    .hit_way(hit_way),
    .line_valid(line_valid)
);

//--- rtl/dcache_tag_top.sv
`timescale 1ns/1ps

module dcache_tag_top #(
    parameter int index_bits  = dcache_pkg::def_index_bits,
    parameter int tag_bits    = dcache_pkg::def_tag_bits,
    parameter int offset_bits = dcache_pkg::def_offset_bits
) (
    input  logic                                       clk,
    input  logic                                       arst_n,
    input  logic                                       lookup,
    input  logic                                       fill,
    input  logic                                       mark_dirty,
    input  logic [index_bits+tag_bits+offset_bits-1:0] addr,
    input  dcache_pkg::way_t                           fill_way,
    input  logic                                       fill_dirty,
    output logic                                       resp_valid,
    output logic                                       hit,
    output dcache_pkg::way_t                           hit_way,
    output logic                                       hit_dirty,
    output dcache_pkg::way_t                           victim_way,
    output logic                                       victim_valid,
    output logic [tag_bits-1:0]                        victim_tag,
    output logic                                       victim_dirty,
    output logic                                       complete
);
    import dcache_pkg::*;

    logic [index_bits-1:0]              set_index;
    logic [tag_bits-1:0]                req_tag;
    logic                               wr_dirty, set_valid;
    logic [num_ways-1:0]                tag_we, dirty_we;
    logic                               lookup_q, write_q;
    way_t                               write_way;
    logic [num_ways-1:0]                match, line_valid, line_dirty;
    logic [num_ways-1:0][tag_bits-1:0]  line_tag;

    dtag_req #(.index_bits(index_bits), .tag_bits(tag_bits), .offset_bits(offset_bits)) u_req (
        .clk, .arst_n, .lookup, .fill, .mark_dirty, .addr, .fill_way, .fill_dirty,
        .set_index, .req_tag, .wr_dirty, .set_valid, .tag_we, .dirty_we,
        .lookup_q, .write_q, .write_way
    );

    for (genvar w = 0; w < num_ways; w++) begin : g_way
        dtag_way #(.index_bits(index_bits), .tag_bits(tag_bits)) u_way (
            .clk, .arst_n, .set_index, .req_tag, .wr_dirty, .set_valid,
            .tag_we(tag_we[w]), .dirty_we(dirty_we[w]),
            .match(match[w]), .line_valid(line_valid[w]),
            .line_dirty(line_dirty[w]), .line_tag(line_tag[w])
        );
    end

    dtag_resolve #(.index_bits(index_bits), .tag_bits(tag_bits)) u_resolve (
        .clk, .arst_n, .lookup_q, .write_q, .set_valid, .write_way, .set_index,
        .match, .line_valid, .line_dirty, .line_tag,
        .resp_valid, .hit, .hit_way, .hit_dirty, .victim_way, .victim_valid,
        .victim_tag, .victim_dirty, .complete
    );

endmodule

//--- rtl/dtag_resolve.sv
`timescale 1ns/1ps

module dtag_resolve #(
    parameter int index_bits = dcache_pkg::def_index_bits,
    parameter int tag_bits   = dcache_pkg::def_tag_bits
) (
    input  logic                                         clk,
    input  logic                                         arst_n,
    input  logic                                         lookup_q,
    input  logic                                         write_q,
    input  logic                                         set_valid,   // marks a fill
    input  dcache_pkg::way_t                             write_way,
    input  logic [index_bits-1:0]                        set_index,
    input  logic [dcache_pkg::num_ways-1:0]              match,
    input  logic [dcache_pkg::num_ways-1:0]              line_valid,
    input  logic [dcache_pkg::num_ways-1:0]              line_dirty,
    input  logic [dcache_pkg::num_ways-1:0][tag_bits-1:0] line_tag,
    output logic                                         resp_valid,
    output logic                                         hit,
    output dcache_pkg::way_t                             hit_way,
    output logic                                         hit_dirty,
    output dcache_pkg::way_t                             victim_way,
    output logic                                         victim_valid,
    output logic [tag_bits-1:0]                          victim_tag,
    output logic                                         victim_dirty,
    output logic                                         complete
);
    import dcache_pkg::*;

    localparam int num_sets = 1 << index_bits;

    logic                  lookup_d, write_d, fill_d;  // aligned with way outputs
    way_t                  write_way_d;
    logic [index_bits-1:0] index_d;
    logic [num_sets-1:0]   lru_bits;                   // one bit per set, names victim

    logic any_hit;
    way_t hit_sel;
    logic has_inv;
    way_t inv_sel;
    logic lru_upd;
    way_t lru_upd_way;
    way_t lru_cur;     // lru after this request, write first
    way_t vict_sel;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            lookup_d <= 1'b0;
            write_d  <= 1'b0;
            fill_d   <= 1'b0;
        end else begin
            lookup_d <= lookup_q;
            write_d  <= write_q;
            fill_d   <= set_valid;
        end
    end

    always_ff @(posedge clk) begin
        write_way_d <= write_way;
        index_d     <= set_index;
    end

    always_comb begin
        hit_sel = '0;
        inv_sel = '0;
        for (int w = num_ways - 1; w >= 0; w--) begin  // lowest way wins
            if (match[w]) hit_sel = way_t'(w);
            if (!line_valid[w]) inv_sel = way_t'(w);
        end
        any_hit     = lookup_d & (|match);
        has_inv     = ~(&line_valid);
        lru_upd     = any_hit | fill_d;
        lru_upd_way = fill_d ? write_way_d : hit_sel;
        lru_cur     = lru_upd ? ~lru_upd_way : lru_bits[index_d];
        vict_sel    = has_inv ? inv_sel : lru_cur;  // invalid way first
    end

    // lru field, points away from the way just used
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)      lru_bits <= '0;
        else if (lru_upd) lru_bits[index_d] <= ~lru_upd_way;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            resp_valid <= 1'b0;
            complete   <= 1'b0;
            hit        <= 1'b0;
        end else begin
            resp_valid <= lookup_d;
            complete   <= write_d;   // pulse after fill or mark_dirty
            hit        <= any_hit;
        end
    end

    // response payload, held between lookups
    always_ff @(posedge clk) begin
        if (lookup_d) begin
            hit_way      <= hit_sel;
            hit_dirty    <= line_dirty[hit_sel];
            victim_way   <= vict_sel;
            victim_valid <= line_valid[vict_sel];
            victim_tag   <= line_tag[vict_sel];
            victim_dirty <= line_dirty[vict_sel];
        end
    end

endmodule

//--- rtl/dtag_way.sv
`timescale 1ns/1ps

module dtag_way #(
    parameter int index_bits = dcache_pkg::def_index_bits,
    parameter int tag_bits   = dcache_pkg::def_tag_bits
) (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic [index_bits-1:0] set_index,   // registered set
    input  logic [tag_bits-1:0]   req_tag,     // registered request tag
    input  logic                  wr_dirty,    // dirty write data
    input  logic                  set_valid,   // valid write data
    input  logic                  tag_we,      // tag and valid write
    input  logic                  dirty_we,    // dirty write
    output logic                  match,       // valid line with equal tag
    output logic                  line_valid,
    output logic                  line_dirty,
    output logic [tag_bits-1:0]   line_tag
);
    localparam int num_sets = 1 << index_bits;

    logic [tag_bits-1:0] tag_ram [num_sets];  // sync single port tag array
    logic                dirty_ram [num_sets]; // sync single port dirty array
    logic [num_sets-1:0] valid_vec;            // flops, cleared on reset

    logic [tag_bits-1:0] tag_q;    // tag read port
    logic                dirty_q;  // dirty read port
    logic                valid_q;  // valid read port
    logic [tag_bits-1:0] tag_d;    // request tag, aligned with read data

    // tag ram, write-through to the read port
    always_ff @(posedge clk) begin
        if (tag_we) begin
            tag_ram[set_index] <= req_tag;
            tag_q              <= req_tag;
        end else begin
            tag_q <= tag_ram[set_index];
        end
        tag_d <= req_tag;  // compare one stage later
    end

    // dirty ram, same port behaviour
    always_ff @(posedge clk) begin
        if (dirty_we) begin
            dirty_ram[set_index] <= wr_dirty;
            dirty_q              <= wr_dirty;
        end else begin
            dirty_q <= dirty_ram[set_index];
        end
    end

    // valid bits
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_vec <= '0;
            valid_q   <= 1'b0;
        end else if (tag_we) begin
            valid_vec[set_index] <= set_valid;
            valid_q              <= set_valid;  // written value seen at once
        end else begin
            valid_q <= valid_vec[set_index];
        end
    end

    // tag compare
    assign match      = valid_q && (tag_q == tag_d);
    assign line_valid = valid_q;
    assign line_dirty = dirty_q;
    assign line_tag   = tag_q;

endmodule

//--- rtl/dtag_req.sv
`timescale 1ns/1ps

module dtag_req #(
    parameter int index_bits  = dcache_pkg::def_index_bits,
    parameter int tag_bits    = dcache_pkg::def_tag_bits,
    parameter int offset_bits = dcache_pkg::def_offset_bits
) (
    input  logic                                      clk,
    input  logic                                      arst_n,
    input  logic                                      lookup,      // read strobe
    input  logic                                      fill,        // line install strobe
    input  logic                                      mark_dirty,  // store hit strobe
    input  logic [index_bits+tag_bits+offset_bits-1:0] addr,
    input  dcache_pkg::way_t                          fill_way,    // way picked by controller
    input  logic                                      fill_dirty,  // dirty state of new line
    output logic [index_bits-1:0]                     set_index,   // common to all ways
    output logic [tag_bits-1:0]                       req_tag,     // common to all ways
    output logic                                      wr_dirty,    // dirty write data
    output logic                                      set_valid,   // valid write data
    output logic [dcache_pkg::num_ways-1:0]           tag_we,      // one-hot per way
    output logic [dcache_pkg::num_ways-1:0]           dirty_we,    // one-hot per way
    output logic                                      lookup_q,
    output logic                                      write_q,     // fill or mark_dirty
    output dcache_pkg::way_t                          write_way
);
    import dcache_pkg::*;

    logic [num_ways-1:0] way_dec;   // fill_way as one-hot
    logic                any_req;   // some strobe this cycle

    assign any_req = lookup | fill | mark_dirty;

    always_comb begin
        way_dec           = '0;
        way_dec[fill_way] = 1'b1;
    end

    // strobes and write enables
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            lookup_q  <= 1'b0;
            write_q   <= 1'b0;
            set_valid <= 1'b0;
            tag_we    <= '0;
            dirty_we  <= '0;
        end else begin
            lookup_q  <= lookup;
            write_q   <= fill | mark_dirty;  // both raise complete later
            set_valid <= fill;               // only a fill installs a line
            tag_we    <= fill ? way_dec : '0;
            dirty_we  <= (fill | mark_dirty) ? way_dec : '0;
        end
    end

    // address fields and write data, offset dropped here
    always_ff @(posedge clk) begin
        if (any_req) begin
            set_index <= addr[offset_bits +: index_bits];
            req_tag   <= addr[offset_bits+index_bits +: tag_bits];
            wr_dirty  <= fill ? fill_dirty : 1'b1;  // mark_dirty always sets
            write_way <= fill_way;
        end
    end

endmodule

//--- rtl/dcache_pkg.sv
package dcache_pkg;

    // two ways, tied to the single lru bit per set
    localparam int num_ways = 2;

    // way number, one bit wide for two ways
    typedef logic [$clog2(num_ways)-1:0] way_t;

    // default address split
    localparam int def_index_bits  = 6;   // 64 sets
    localparam int def_tag_bits    = 21;  // upper address bits kept in the tag ram
    localparam int def_offset_bits = 5;   // 32 byte line, not stored

    // address layout, msb first:
    //   tag | index | offset
    //
    // the front end drops the offset, the ways see only index and tag,
    // and the resolve block sees only way outputs and the lru field

endpackage
